// File: verilog.f
gmii_pkg.sv
frame_pkg.sv
fcs_strip_line.sv
rx_frame_ctrl.sv
frame_len_shaper.sv
gmii_rx_top.sv
tb_gmii_rx.sv

// File: Bender.yml
package:
  name: gmii_rx

sources:
  - files:
      - gmii_pkg.sv
      - frame_pkg.sv
      - fcs_strip_line.sv
      - rx_frame_ctrl.sv
      - frame_len_shaper.sv
      - gmii_rx_top.sv

  - target: test
    files:
      - tb_gmii_rx.sv

# Simulation top: tb_gmii_rx
# Synthesis top: gmii_rx_top

// File: tb_gmii_rx.sv
// GMII receive front end testbench

module tb_gmii_rx;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;
    localparam int IDLE_GAP     = 80;
    localparam int LATENCY      = 7;
    localparam int MIN_LEN      = int'(frame_pkg::DEFAULT_MIN_LEN);
    localparam int MAX_LEN      = int'(frame_pkg::DEFAULT_MAX_LEN);

    logic                 clk = 1'b0;
    logic                 rst_n;
    gmii_pkg::gmii_beat_t gmii_in;
    gmii_pkg::gmii_beat_t gmii_out;

    integer               seed = 84;
    int                   cycle = 0;
    int                   timeout_limit;
    int                   frames_done = 0;
    int                   first_body_cycle;
    int                   out_first_cycle;
    logic                 out_dv_d = 1'b0;
    logic [7:0]           body_q[$];
    logic                 body_er_q[$];
    gmii_pkg::gmii_beat_t exp_q[$];
    gmii_pkg::gmii_beat_t got_q[$];

    gmii_rx_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .gmii_in  (gmii_in),
        .gmii_out (gmii_out)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_limit) begin
            $display("Timeout: no result after %0d cycles", timeout_limit);
            $display("** FAIL **");
            $fatal(1, "run stopped by timeout");
        end
    end

    //////////////////////////////
    // Output monitor
    //////////////////////////////

    always @(negedge clk) begin
        if (gmii_out.dv) begin
            if (!out_dv_d) begin
                out_first_cycle = cycle;
            end
            got_q.push_back(gmii_out);
        end else if (out_dv_d) begin
            frames_done++;
        end
        out_dv_d = gmii_out.dv;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "check failed");
        end
    endtask

    // Preamble, SFD, body, FCS and the idle gap
    function automatic int frame_cycles(input int body_len);
        return 8 + body_len + gmii_pkg::FCS_LEN + IDLE_GAP;
    endfunction

    //////////////////////////////
    // Frame builder
    //////////////////////////////

    task automatic fill_body(input int n, input int er_pos);
        logic [31:0] r;
        body_q.delete();
        body_er_q.delete();
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            body_q.push_back(r[7:0]);
            body_er_q.push_back(i == er_pos);
        end
    endtask

    task automatic drive_beat(input logic dv, input logic er, input logic [7:0] data);
        @(posedge clk);
        gmii_in.dv   <= dv;
        gmii_in.er   <= er;
        gmii_in.data <= data;
    endtask

    task automatic drive_frame(input int bad_pos);
        logic [7:0]  pre;
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            pre = (i == 7) ? gmii_pkg::SFD_BYTE : gmii_pkg::PREAMBLE_BYTE;
            if (i == bad_pos) begin
                pre = 8'h12;
            end
            drive_beat(1'b1, 1'b0, pre);
        end
        for (int i = 0; i < body_q.size(); i++) begin
            drive_beat(1'b1, body_er_q[i], body_q[i]);
            // Counter advances at this same edge
            if (i == 0) begin
                first_body_cycle = cycle + 1;
            end
        end
        for (int i = 0; i < gmii_pkg::FCS_LEN; i++) begin
            r = $random(seed);
            drive_beat(1'b1, 1'b0, r[7:0]);
        end
        repeat (IDLE_GAP) drive_beat(1'b0, 1'b0, 8'h00);
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    task automatic build_expected(input bit dropped);
        gmii_pkg::gmii_beat_t beat;
        int                   n;
        exp_q.delete();
        n = body_q.size();
        if (!dropped) begin
            for (int i = 0; i < n && i < MAX_LEN; i++) begin
                beat.dv   = 1'b1;
                beat.data = body_q[i];
                beat.er   = body_er_q[i] || (n > MAX_LEN && i == MAX_LEN - 1);
                exp_q.push_back(beat);
            end
            // Zero padding up to the minimum
            while (exp_q.size() < MIN_LEN) begin
                beat.dv   = 1'b1;
                beat.er   = 1'b0;
                beat.data = 8'h00;
                exp_q.push_back(beat);
            end
        end
    endtask

    task automatic compare_frame();
        check_value("gmii_out frame length", got_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size(); i++) begin
            check_value($sformatf("gmii_out.data[%0d]", i), got_q[i].data, exp_q[i].data);
            check_value($sformatf("gmii_out.er[%0d]", i), got_q[i].er, exp_q[i].er);
        end
    endtask

    // A negative bad_pos gives a clean preamble
    task automatic run_frame(input int bad_pos);
        int done_before;
        done_before = frames_done;
        got_q.delete();
        build_expected(bad_pos >= 0);
        drive_frame(bad_pos);
        if (exp_q.size() > 0) begin
            while (frames_done == done_before) begin
                @(posedge clk);
            end
            // One unbroken dv run per frame
            check_value("gmii_out.dv run count", frames_done - done_before, 1);
            compare_frame();
        end else begin
            check_value("gmii_out frame count", frames_done - done_before, 0);
            check_value("gmii_out beat count", got_q.size(), 0);
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic normal_frame_passes();
        fill_body(100, -1);
        run_frame(-1);
        check_value("normal frame length", got_q.size(), 100);
    endtask

    task automatic short_frame_pads();
        fill_body(20, -1);
        run_frame(-1);
        check_value("padded frame length", got_q.size(), MIN_LEN);
    endtask

    task automatic oversize_frame_cuts();
        fill_body(1600, -1);
        run_frame(-1);
        check_value("truncated frame length", got_q.size(), MAX_LEN);
        check_value("gmii_out.er on last byte", got_q[MAX_LEN-1].er, 1'b1);
    endtask

    // Third byte corrupted and a good frame behind it
    task automatic bad_preamble_drops();
        fill_body(50, -1);
        run_frame(2);
        fill_body(70, -1);
        run_frame(-1);
    endtask

    task automatic input_er_passes();
        fill_body(100, 29);
        run_frame(-1);
        check_value("gmii_out.er on byte 30", got_q[29].er, 1'b1);
    endtask

    task automatic first_byte_latency();
        fill_body(64, -1);
        run_frame(-1);
        check_value("first byte latency", out_first_cycle - first_body_cycle, LATENCY);
    endtask

    initial begin
        rst_n   = 1'b0;
        gmii_in = '0;
        timeout_limit = 2 * (RESET_CYCLES + frame_cycles(100) + frame_cycles(20)
                        + frame_cycles(1600) + frame_cycles(50) + frame_cycles(70)
                        + frame_cycles(100) + frame_cycles(64)) + 200;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        normal_frame_passes();
        short_frame_pads();
        oversize_frame_cuts();
        bad_preamble_drops();
        input_er_passes();
        first_byte_latency();
        $display("** PASS **");
        $finish;
    end

endmodule

// File: gmii_rx_top.sv
// GMII receive front end

module gmii_rx_top #(
    parameter frame_pkg::frame_len_t MIN_FRAME_LEN = frame_pkg::DEFAULT_MIN_LEN,
    parameter frame_pkg::frame_len_t MAX_FRAME_LEN = frame_pkg::DEFAULT_MAX_LEN
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  gmii_pkg::gmii_beat_t gmii_in,
    output gmii_pkg::gmii_beat_t gmii_out
);

    gmii_pkg::gmii_beat_t  line_beat;
    logic                  frame_start;
    logic                  frame_end;
    frame_pkg::shape_cmd_e cmd;
    logic                  count_clr;
    logic                  below_min;
    logic                  at_max;

    // Sampling and FCS removal
    fcs_strip_line u_strip (
        .clk         (clk),
        .rst_n       (rst_n),
        .gmii_in     (gmii_in),
        .line_beat   (line_beat),
        .frame_start (frame_start),
        .frame_end   (frame_end)
    );

    rx_frame_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .line_beat   (line_beat),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .below_min   (below_min),
        .at_max      (at_max),
        .cmd         (cmd),
        .count_clr   (count_clr)
    );

    // Pad and truncate, registered output
    frame_len_shaper #(
        .MIN_FRAME_LEN (MIN_FRAME_LEN),
        .MAX_FRAME_LEN (MAX_FRAME_LEN)
    ) u_shaper (
        .clk       (clk),
        .rst_n     (rst_n),
        .line_beat (line_beat),
        .cmd       (cmd),
        .count_clr (count_clr),
        .below_min (below_min),
        .at_max    (at_max),
        .gmii_out  (gmii_out)
    );

endmodule

// File: frame_len_shaper.sv
// Frame length shaper

module frame_len_shaper #(
    parameter frame_pkg::frame_len_t MIN_FRAME_LEN = frame_pkg::DEFAULT_MIN_LEN,
    parameter frame_pkg::frame_len_t MAX_FRAME_LEN = frame_pkg::DEFAULT_MAX_LEN
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  gmii_pkg::gmii_beat_t  line_beat,
    input  frame_pkg::shape_cmd_e cmd,
    input  logic                  count_clr,
    output logic                  below_min,
    output logic                  at_max,
    output gmii_pkg::gmii_beat_t  gmii_out
);

    frame_pkg::frame_len_t count;
    logic                  emit;

    //////////////////////////////
    // Byte counter
    //////////////////////////////

    // Every command but IDLE puts a byte on the output
    assign emit = (cmd != frame_pkg::IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (count_clr) begin
            count <= '0;
        end else if (emit) begin
            count <= count + 1'b1;
        end
    end

    assign below_min = (count < MIN_FRAME_LEN);

    // Next byte out would be the last one allowed
    assign at_max = (count == MAX_FRAME_LEN - 1'b1);

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gmii_out <= '0;
        end else begin
            case (cmd)
                frame_pkg::PASS: begin
                    gmii_out <= line_beat;
                end
                frame_pkg::PAD: begin
                    gmii_out.dv   <= 1'b1;
                    gmii_out.er   <= 1'b0;
                    gmii_out.data <= 8'h00;
                end
                frame_pkg::CUT: begin
                    // Flag the truncated frame on its last byte
                    gmii_out.dv   <= 1'b1;
                    gmii_out.er   <= 1'b1;
                    gmii_out.data <= line_beat.data;
                end
                default: begin
                    gmii_out <= '0;
                end
            endcase
        end
    end

    // The FSM must stop issuing bytes once at_max was seen
    a_count_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= MAX_FRAME_LEN
    ) else $error("byte count %0d above MAX_FRAME_LEN", count);

endmodule

// File: rx_frame_ctrl.sv
// Receive frame control FSM

module rx_frame_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  gmii_pkg::gmii_beat_t   line_beat,
    input  logic                   frame_start,
    input  logic                   frame_end,
    input  logic                   below_min,
    input  logic                   at_max,
    output frame_pkg::shape_cmd_e  cmd,
    output logic                   count_clr
);

    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_PREAMBLE = 3'd1,
        ST_BODY     = 3'd2,
        ST_PAD      = 3'd3,
        ST_DROP     = 3'd4
    } state_e;

    state_e state;
    state_e state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////
    // Next state and command
    //////////////////////////////

    always_comb begin
        state_nxt = state;
        cmd       = frame_pkg::IDLE;
        count_clr = 1'b0;
        case (state)
            ST_IDLE: begin
                if (frame_start) begin
                    state_nxt = ST_PREAMBLE;
                end
            end
            ST_PREAMBLE: begin
                if (frame_end) begin
                    // Runt, never saw the SFD
                    state_nxt = ST_IDLE;
                end else if (line_beat.dv) begin
                    if (line_beat.data == gmii_pkg::SFD_BYTE) begin
                        state_nxt = ST_BODY;
                        count_clr = 1'b1;
                    end else if (line_beat.data != gmii_pkg::PREAMBLE_BYTE) begin
                        state_nxt = ST_DROP;
                    end
                end
            end
            ST_BODY: begin
                if (frame_end) begin
                    // Padding starts right behind the last body byte
                    if (below_min) begin
                        cmd       = frame_pkg::PAD;
                        state_nxt = ST_PAD;
                    end else begin
                        state_nxt = ST_IDLE;
                    end
                end else if (line_beat.dv) begin
                    if (at_max) begin
                        cmd       = frame_pkg::CUT;
                        state_nxt = ST_DROP;
                    end else begin
                        cmd = frame_pkg::PASS;
                    end
                end
            end
            ST_PAD: begin
                if (below_min) begin
                    cmd = frame_pkg::PAD;
                end else begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_DROP: begin
                // Rest of the frame is discarded
                if (frame_end) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // Idle gap on the input covers the longest pad run
    a_no_start_while_pad: assert property (
        @(posedge clk) disable iff (!rst_n)
        state == ST_PAD |-> !frame_start
    ) else $error("frame_start while padding");

endmodule

// File: fcs_strip_line.sv
// FCS strip delay line

module fcs_strip_line (
    input  logic                 clk,
    input  logic                 rst_n,
    input  gmii_pkg::gmii_beat_t gmii_in,
    output gmii_pkg::gmii_beat_t line_beat,
    output logic                 frame_start,
    output logic                 frame_end
);

    gmii_pkg::gmii_beat_t in_r;
    logic                 dv_d;
    logic                 dv_fall;
    gmii_pkg::gmii_beat_t stage [gmii_pkg::FCS_LEN];
    gmii_pkg::gmii_beat_t tail;
    logic                 push_out;
    logic                 line_dv_d;

    //////////////////////////////
    // Input sampling
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_r <= '0;
            dv_d <= 1'b0;
        end else begin
            in_r <= gmii_in;
            dv_d <= in_r.dv;
        end
    end

    // End of a dv run
    assign dv_fall = dv_d & ~in_r.dv;

    //////////////////////////////
    // Delay line
    //////////////////////////////

    // Oldest byte held back
    assign tail = stage[gmii_pkg::FCS_LEN-1];

    // Leaves only when FCS_LEN later bytes of the same run are behind it
    assign push_out = tail.dv & in_r.dv;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < gmii_pkg::FCS_LEN; i++) begin
                stage[i] <= '0;
            end
        end else if (dv_fall) begin
            // Whatever is still in the line is the FCS, throw it away
            for (int i = 0; i < gmii_pkg::FCS_LEN; i++) begin
                stage[i].dv <= 1'b0;
            end
        end else begin
            stage[0] <= in_r;
            for (int i = 1; i < gmii_pkg::FCS_LEN; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_beat <= '0;
            line_dv_d <= 1'b0;
        end else begin
            line_beat <= push_out ? tail : '0;
            line_dv_d <= line_beat.dv;
        end
    end

    //////////////////////////////
    // Frame edges
    //////////////////////////////

    // First push out of a run, one cycle ahead of line_beat
    assign frame_start = push_out & ~line_beat.dv;

    // Line just went empty
    assign frame_end = line_dv_d & ~line_beat.dv;

    // The line refills through the whole delay after a frame ends
    a_no_beat_after_end: assert property (
        @(posedge clk) disable iff (!rst_n)
        frame_end |=> !line_beat.dv
    ) else $error("line_beat.dv high right after frame_end");

endmodule

// File: frame_pkg.sv
// Frame length and shaper command types

package frame_pkg;

    //////////////////////////////
    // Length bookkeeping
    //////////////////////////////

    // Byte count, wide enough for a full-size frame body
    typedef logic [10:0] frame_len_t;

    // Minimum body without FCS
    localparam frame_len_t DEFAULT_MIN_LEN = 11'd60;

    // Maximum body without FCS
    localparam frame_len_t DEFAULT_MAX_LEN = 11'd1514;

    //////////////////////////////
    // Shaper command
    //////////////////////////////

    // IDLE clears the output beat
    // PASS forwards the body byte
    // PAD  emits a zero byte
    // CUT  forwards the byte with er set, last of the frame
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        PASS = 2'd1,
        PAD  = 2'd2,
        CUT  = 2'd3
    } shape_cmd_e;

endpackage

// File: gmii_pkg.sv
// GMII beat and framing constants

package gmii_pkg;

    //////////////////////////////
    // One GMII byte time
    //////////////////////////////

    typedef struct packed {
        logic       dv;
        logic       er;
        logic [7:0] data;
    } gmii_beat_t;

    //////////////////////////////
    // Ethernet framing bytes
    //////////////////////////////

    // Repeated before the delimiter
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;

    // Start of frame delimiter, last byte before the body
    localparam logic [7:0] SFD_BYTE = 8'hD5;

    // Trailing CRC-32 bytes withheld from the output
    localparam int FCS_LEN = 4;

endpackage
